//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_dbg_top
RTL_TOP   ?= dbg_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/apb_arbiter.sv
`timescale 1ns/10ps

module apb_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  dbg_pkg::apb_req_t dbg_req,
    output dbg_pkg::apb_rsp_t dbg_rsp,
    input  dbg_pkg::apb_req_t fetch_req,
    output dbg_pkg::apb_rsp_t fetch_rsp,
    output dbg_pkg::apb_req_t mem_req,
    input  dbg_pkg::apb_rsp_t mem_rsp
);

    logic locked;
    logic owner;       // set when the fetch engine holds the bus
    logic grant_fetch;

    // the debug engine wins whenever the bus is free
    assign grant_fetch = locked ? owner : (~dbg_req.psel & fetch_req.psel);

    always_comb begin
        mem_req = grant_fetch ? fetch_req : dbg_req;
        // a master that already waits in access gets a fresh setup cycle on the slave
        mem_req.penable = (grant_fetch ? fetch_req.penable : dbg_req.penable) & locked;
    end

    always_comb begin
        dbg_rsp.prdata   = mem_rsp.prdata;
        dbg_rsp.pready   = mem_rsp.pready & ~grant_fetch;
        fetch_rsp.prdata = mem_rsp.prdata;
        fetch_rsp.pready = mem_rsp.pready & grant_fetch;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= 1'b0;
        end else if (!locked) begin
            if (dbg_req.psel || fetch_req.psel) begin
                locked <= 1'b1;
                owner  <= grant_fetch;
            end
        end else if (mem_rsp.pready) begin
            locked <= 1'b0;
        end
    end

endmodule

//--- hdl/apb_ram.sv
`timescale 1ns/10ps

module apb_ram #(
    parameter int mem_words = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  dbg_pkg::apb_req_t bus_req,
    output dbg_pkg::apb_rsp_t bus_rsp
);
    import dbg_pkg::*;

    localparam int aw = $clog2(mem_words);

    logic [xlen-1:0] mem [mem_words];
    logic [aw-1:0]   idx;
    logic            access;

    assign idx            = bus_req.paddr[aw+1:2]; // word index, upper bits fold over
    assign access         = bus_req.psel & bus_req.penable;
    assign bus_rsp.pready = access;
    assign bus_rsp.prdata = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (access && bus_req.pwrite) begin
            mem[idx] <= bus_req.pwdata;
        end
    end

endmodule

//--- hdl/dbg_cmd.sv
`timescale 1ns/10ps

module dbg_cmd (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [7:0]               recv_data,
    input  logic                     recv_valid,
    output logic [7:0]               send_data,
    output logic                     led,
    output logic                     run,
    output logic                     step,
    input  logic [dbg_pkg::xlen-1:0] pc,
    input  logic [dbg_pkg::xlen-1:0] instr,
    output dbg_pkg::apb_req_t        bus_req,
    input  dbg_pkg::apb_rsp_t        bus_rsp
);
    import dbg_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_echo,
        st_addr,
        st_wdata,
        st_reply
    } state_t;

    state_t          state;
    logic [xlen-1:0] reply_buf;
    logic [2:0]      reply_cnt;
    logic            is_write;
    logic [7:0]      widx;
    logic [1:0]      wcnt;
    logic [xlen-1:0] wdata;

    function automatic logic [xlen-1:0] word_addr(input logic [7:0] idx);
        return {{(xlen - 10){1'b0}}, idx, 2'b00};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= st_idle;
            send_data       <= '0;
            led             <= 1'b0;
            run             <= 1'b0;
            step            <= 1'b0;
            reply_cnt       <= '0;
            is_write        <= 1'b0;
            wcnt            <= '0;
            bus_req.psel    <= 1'b0;
            bus_req.penable <= 1'b0;
        end else begin
            step <= 1'b0;
            if (recv_valid) begin
                case (state)
                    st_idle: begin
                        send_data <= hdr_none;
                        case (recv_data)
                            cmd_nop:        state <= st_idle;
                            cmd_echo:       state <= st_echo;
                            cmd_toggle_led: led <= ~led;
                            cmd_run:        run <= 1'b1;
                            cmd_halt:       run <= 1'b0;
                            cmd_step:       step <= 1'b1;
                            cmd_get_pc, cmd_get_instr: begin
                                reply_buf <= (recv_data == cmd_get_pc) ? pc : instr;
                                reply_cnt <= 3'd4;
                                send_data <= hdr_word;
                                state     <= st_reply;
                            end
                            cmd_read_mem, cmd_write_mem: begin
                                is_write <= (recv_data == cmd_write_mem);
                                state    <= st_addr;
                            end
                            default:        send_data <= reply_unknown;
                        endcase
                    end
                    st_echo: begin
                        send_data <= recv_data;
                        state     <= st_idle;
                    end
                    st_addr: begin
                        widx <= recv_data;
                        wcnt <= '0;
                        if (is_write) begin
                            send_data <= hdr_none;
                            state     <= st_wdata;
                        end else begin
                            bus_req.psel    <= 1'b1; // reply_buf fills in well before the next byte
                            bus_req.penable <= 1'b0;
                            bus_req.pwrite  <= 1'b0;
                            bus_req.paddr   <= word_addr(recv_data);
                            reply_cnt       <= 3'd4;
                            send_data       <= hdr_word;
                            state           <= st_reply;
                        end
                    end
                    st_wdata: begin
                        wdata     <= {wdata[xlen-9:0], recv_data};
                        wcnt      <= wcnt + 2'd1;
                        send_data <= hdr_none;
                        if (wcnt == 2'd3) begin
                            bus_req.psel    <= 1'b1;
                            bus_req.penable <= 1'b0;
                            bus_req.pwrite  <= 1'b1;
                            bus_req.paddr   <= word_addr(widx);
                            bus_req.pwdata  <= {wdata[xlen-9:0], recv_data};
                            state           <= st_idle;
                        end
                    end
                    st_reply: begin
                        send_data <= reply_buf[xlen-1 -: 8]; // incoming bytes are ignored here
                        reply_buf <= reply_buf << 8;
                        reply_cnt <= reply_cnt - 3'd1;
                        if (reply_cnt == 3'd1) begin
                            state <= st_idle;
                        end
                    end
                    default: begin
                        send_data <= reply_unknown;
                        state     <= st_idle;
                    end
                endcase
            end
            if (bus_req.psel && !bus_req.penable) begin
                bus_req.penable <= 1'b1;
            end else if (bus_req.penable && bus_rsp.pready) begin
                bus_req.psel    <= 1'b0;
                bus_req.penable <= 1'b0;
                if (!bus_req.pwrite) begin
                    reply_buf <= bus_rsp.prdata;
                end
            end
        end
    end

endmodule

//--- hdl/dbg_pkg.sv
package dbg_pkg;

    localparam int xlen = 32;

    // request driven by an APB master
    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [xlen-1:0] paddr;
        logic [xlen-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic            pready;
        logic [xlen-1:0] prdata;
    } apb_rsp_t;

    localparam logic [7:0] cmd_nop        = 8'h00;
    localparam logic [7:0] cmd_echo       = 8'h01;
    localparam logic [7:0] cmd_toggle_led = 8'h02;
    localparam logic [7:0] cmd_run        = 8'h03;
    localparam logic [7:0] cmd_halt       = 8'h04;
    localparam logic [7:0] cmd_step       = 8'h05;
    localparam logic [7:0] cmd_get_pc     = 8'h06;
    localparam logic [7:0] cmd_get_instr  = 8'h07;
    localparam logic [7:0] cmd_read_mem   = 8'h08;
    localparam logic [7:0] cmd_write_mem  = 8'h09;

    localparam logic [7:0] reply_unknown  = 8'hff;

    localparam logic [7:0] hdr_none       = 8'h00; // no data bytes follow
    localparam logic [7:0] hdr_word       = 8'h04; // one word follows, msb first

endpackage

//--- hdl/dbg_top.sv
`timescale 1ns/10ps

module dbg_top #(
    parameter int mem_words = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic mosi,
    input  logic ss_n,
    output logic miso,
    output logic led
);
    import dbg_pkg::*;

    logic [7:0]      send_data;
    logic [7:0]      recv_data;
    logic            recv_valid;
    logic            run;
    logic            step;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    apb_req_t        dbg_req;
    apb_rsp_t        dbg_rsp;
    apb_req_t        fetch_req;
    apb_rsp_t        fetch_rsp;
    apb_req_t        mem_req;
    apb_rsp_t        mem_rsp;

    spi_slave i_spi (
        .clk, .rst, .sclk, .mosi, .ss_n, .miso,
        .send_data, .recv_data, .recv_valid
    );

    dbg_cmd i_cmd (
        .clk, .rst, .recv_data, .recv_valid, .send_data,
        .led, .run, .step, .pc, .instr,
        .bus_req(dbg_req), .bus_rsp(dbg_rsp)
    );

    fetch_unit #(.mem_words(mem_words)) i_fetch (
        .clk, .rst, .run, .step, .pc, .instr,
        .bus_req(fetch_req), .bus_rsp(fetch_rsp)
    );

    apb_arbiter i_arb (
        .clk, .rst, .dbg_req, .dbg_rsp, .fetch_req, .fetch_rsp, .mem_req, .mem_rsp
    );

    apb_ram #(.mem_words(mem_words)) i_ram (
        .clk, .rst, .bus_req(mem_req), .bus_rsp(mem_rsp)
    );

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter int mem_words = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     run,
    input  logic                     step,
    output logic [dbg_pkg::xlen-1:0] pc,
    output logic [dbg_pkg::xlen-1:0] instr,
    output dbg_pkg::apb_req_t        bus_req,
    input  dbg_pkg::apb_rsp_t        bus_rsp
);
    import dbg_pkg::*;

    localparam logic [xlen-1:0] pc_mask = xlen'(mem_words * 4 - 1);

    logic            step_pend;
    logic            want;
    logic [xlen-1:0] pc_next;

    assign pc_next = (pc + xlen'(4)) & pc_mask; // wraps at the end of the RAM
    assign want    = run | step | step_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc              <= '0;
            instr           <= '0;
            step_pend       <= 1'b0;
            bus_req.psel    <= 1'b0;
            bus_req.penable <= 1'b0;
        end else begin
            if (step) begin
                step_pend <= 1'b1;
            end
            if (!bus_req.psel) begin
                if (want) begin
                    bus_req.psel    <= 1'b1;
                    bus_req.penable <= 1'b0;
                    bus_req.pwrite  <= 1'b0;
                    bus_req.paddr   <= pc;
                    bus_req.pwdata  <= '0;
                    step_pend       <= 1'b0;
                end
            end else if (!bus_req.penable) begin
                bus_req.penable <= 1'b1;
            end else if (bus_rsp.pready) begin
                instr           <= bus_rsp.prdata;
                pc              <= pc_next;
                bus_req.penable <= 1'b0;
                bus_req.paddr   <= pc_next;
                bus_req.psel    <= want; // back to back while running
                step_pend       <= 1'b0;
            end
        end
    end

endmodule

//--- hdl/spi_slave.sv
`timescale 1ns/10ps

module spi_slave (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss_n,
    output logic       miso,
    input  logic [7:0] send_data,
    output logic [7:0] recv_data,
    output logic       recv_valid
);

    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ss_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       active;
    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       reload;

    assign active    = ~ss_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign miso      = active & tx_shift[7]; // held low while deselected

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            ss_sync   <= '1;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            ss_sync   <= {ss_sync[0], ss_n};
            sclk_prev <= sclk_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            recv_valid <= 1'b0;
            reload     <= 1'b0;
            tx_shift   <= '0;
        end else begin
            recv_valid <= 1'b0;
            reload     <= recv_valid; // send_data holds the reply one cycle after the strobe
            if (!active) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                rx_shift <= {rx_shift[6:0], mosi_sync[1]};
                bit_cnt  <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    recv_data  <= {rx_shift[6:0], mosi_sync[1]};
                    recv_valid <= 1'b1;
                end
            end else if (sclk_fall && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0}; // no shift on the falling edge after bit 8
            end
            if (reload) begin
                tx_shift <= send_data;
            end
        end
    end

endmodule

//--- src.f
hdl/dbg_pkg.sv
hdl/spi_slave.sv
hdl/dbg_cmd.sv
hdl/fetch_unit.sv
hdl/apb_arbiter.sv
hdl/apb_ram.sv
hdl/dbg_top.sv
verif/tb_dbg_top.sv

//--- verif/tb_dbg_top.sv
`timescale 1ns/10ps

module tb_dbg_top;

    localparam int mem_words = 64;

    localparam logic [7:0] cmd_nop        = 8'h00;
    localparam logic [7:0] cmd_echo       = 8'h01;
    localparam logic [7:0] cmd_toggle_led = 8'h02;
    localparam logic [7:0] cmd_run        = 8'h03;
    localparam logic [7:0] cmd_halt       = 8'h04;
    localparam logic [7:0] cmd_step       = 8'h05;
    localparam logic [7:0] cmd_get_pc     = 8'h06;
    localparam logic [7:0] cmd_get_instr  = 8'h07;
    localparam logic [7:0] cmd_read_mem   = 8'h08;
    localparam logic [7:0] cmd_write_mem  = 8'h09;

    logic        clk;
    logic        rst;
    logic        sclk;
    logic        mosi;
    logic        ss_n;
    logic        miso;
    logic        led;
    logic [15:0] lfsr;
    logic [7:0]  tx_buf [8];
    logic [7:0]  rx_buf [8];
    logic [31:0] mem_model [mem_words]; // what the RAM should hold
    int          errors;
    int          tests;

    dbg_top #(.mem_words(mem_words)) i_dut (
        .clk, .rst, .sclk, .mosi, .ss_n, .miso, .led
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("CHECK FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, sig, got, exp);
    endtask

    task automatic test_done(input string name, input int start);
        tests++;
        if (errors == start)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - start);
    endtask

    // miso is taken just before each rising sclk edge of mode 0
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int b = 7; b >= 0; b--) begin
            mosi = tx[b];
            tick(4);
            rx[b] = miso;
            sclk = 1'b1;
            tick(4);
            sclk = 1'b0;
        end
    endtask

    task automatic spi_xfer(input int n);
        logic [7:0] rx;
        ss_n = 1'b0;
        tick(4);
        for (int k = 0; k < n; k++) begin
            spi_byte(tx_buf[k], rx);
            rx_buf[k] = rx;
        end
        tick(8);
        ss_n = 1'b1;
        tick(8);
    endtask

    task automatic send_single(input logic [7:0] cmd);
        tx_buf[0] = cmd;
        spi_xfer(1);
    endtask

    // header comes back during byte 1, the word during bytes 2 to 5
    task automatic get_reg(input logic [7:0] cmd, output logic [31:0] word,
                           output logic [7:0] hdr);
        tx_buf[0] = cmd;
        for (int k = 1; k < 6; k++) tx_buf[k] = cmd_nop;
        spi_xfer(6);
        hdr  = rx_buf[1];
        word = {rx_buf[2], rx_buf[3], rx_buf[4], rx_buf[5]};
    endtask

    task automatic mem_read(input logic [7:0] idx, output logic [31:0] word,
                            output logic [7:0] hdr);
        tx_buf[0] = cmd_read_mem;
        tx_buf[1] = idx;
        for (int k = 2; k < 7; k++) tx_buf[k] = cmd_nop;
        spi_xfer(7);
        hdr  = rx_buf[2];
        word = {rx_buf[3], rx_buf[4], rx_buf[5], rx_buf[6]};
    endtask

    task automatic mem_write(input logic [7:0] idx, input logic [31:0] word);
        tx_buf[0] = cmd_write_mem;
        tx_buf[1] = idx;
        tx_buf[2] = word[31:24];
        tx_buf[3] = word[23:16];
        tx_buf[4] = word[15:8];
        tx_buf[5] = word[7:0];
        spi_xfer(6);
        mem_model[idx[5:0]] = word;
    endtask

    task automatic wait_led(input logic want);
        int n;
        n = 0;
        while (led !== want && n < 100) begin
            tick(1);
            n++;
        end
        if (led !== want) begin
            errors++;
            $display("timeout at %0t ns: led never became %0b", $time, want);
        end
    endtask

    task automatic test_echo();
        int         start;
        logic [7:0] arg;
        start = errors;
        for (int i = 0; i < 3; i++) begin
            arg = 8'(rand_bits(8));
            tx_buf[0] = cmd_echo;
            tx_buf[1] = arg;
            tx_buf[2] = cmd_nop;
            spi_xfer(3);
            if (rx_buf[1] !== 8'h00) report_mismatch("echo header", 32'(rx_buf[1]), 32'h0);
            if (rx_buf[2] !== arg) report_mismatch("echo byte", 32'(rx_buf[2]), 32'(arg));
        end
        tx_buf[0] = 8'h5a;
        tx_buf[1] = cmd_nop;
        spi_xfer(2);
        if (rx_buf[1] !== 8'hff) report_mismatch("unknown reply", 32'(rx_buf[1]), 32'hff);
        test_done("echo and unknown command", start);
    endtask

    task automatic test_led();
        int   start;
        logic led_exp;
        start   = errors;
        led_exp = 1'b0;
        if (led !== 1'b0) report_mismatch("led", 32'(led), 32'h0);
        for (int i = 0; i < 3; i++) begin
            send_single(cmd_toggle_led);
            led_exp = ~led_exp;
            wait_led(led_exp);
        end
        test_done("led toggle", start);
    endtask

    task automatic test_mem_rw();
        int          start;
        logic [7:0]  idx;
        logic [7:0]  hdr;
        logic [31:0] word;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            idx = 8'(32 + rand_bits(5));
            mem_write(idx, rand_bits(32));
        end
        for (int i = 32; i < 64; i++) begin // unwritten cells are expected as zero
            mem_read(8'(i), word, hdr);
            if (hdr !== 8'h04) report_mismatch("read header", 32'(hdr), 32'h4);
            if (word !== mem_model[i[5:0]]) begin
                report_mismatch("read word", word, mem_model[i[5:0]]);
            end
        end
        test_done("memory write and read", start);
    endtask

    task automatic test_step();
        int          start;
        logic [7:0]  hdr;
        logic [31:0] pc_prev;
        logic [31:0] pc_now;
        logic [31:0] ins;
        start = errors;
        for (int i = 0; i < 4; i++) mem_write(8'(i), rand_bits(32));
        get_reg(cmd_get_pc, pc_prev, hdr);
        if (pc_prev !== 32'h0) report_mismatch("pc after reset", pc_prev, 32'h0);
        for (int i = 0; i < 4; i++) begin
            send_single(cmd_step);
            get_reg(cmd_get_pc, pc_now, hdr);
            if (hdr !== 8'h04) report_mismatch("pc header", 32'(hdr), 32'h4);
            if (pc_now !== ((pc_prev + 32'd4) & 32'hff)) begin
                report_mismatch("pc", pc_now, (pc_prev + 32'd4) & 32'hff);
            end
            get_reg(cmd_get_instr, ins, hdr);
            if (ins !== mem_model[pc_prev[7:2]]) begin
                report_mismatch("instr", ins, mem_model[pc_prev[7:2]]);
            end
            pc_prev = pc_now;
        end
        test_done("single step", start);
    endtask

    task automatic test_run_halt();
        int          start;
        logic [7:0]  idx;
        logic [7:0]  idx_list [8];
        logic [7:0]  hdr;
        logic [31:0] word;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] ins;
        logic [5:0]  prev_idx;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            idx_list[i] = 8'(rand_bits(6));
            mem_write(idx_list[i], rand_bits(32));
        end
        send_single(cmd_run);
        for (int i = 0; i < 8; i++) begin // each read targets a written cell
            idx = idx_list[i];
            mem_read(idx, word, hdr);
            if (hdr !== 8'h04) report_mismatch("read header", 32'(hdr), 32'h4);
            if (word !== mem_model[idx[5:0]]) begin
                report_mismatch("read word", word, mem_model[idx[5:0]]);
            end
        end
        send_single(cmd_halt);
        get_reg(cmd_get_pc, pc_a, hdr);
        get_reg(cmd_get_pc, pc_b, hdr);
        if (pc_b !== pc_a) report_mismatch("halted pc", pc_b, pc_a);
        if (pc_a[1:0] !== 2'b00 || pc_a >= 32'd256) begin
            errors++;
            $display("pc 0x%08h after halt is not a word address inside the RAM", pc_a);
        end
        get_reg(cmd_get_instr, ins, hdr);
        prev_idx = pc_a[7:2] - 6'd1; // the last fetch was one word below pc
        if (ins !== mem_model[prev_idx]) begin
            report_mismatch("halted instr", ins, mem_model[prev_idx]);
        end
        test_done("run and halt", start);
    endtask

    initial begin
        rst    = 1'b1;
        sclk   = 1'b0;
        mosi   = 1'b0;
        ss_n   = 1'b1;
        lfsr   = 16'd35332;
        errors = 0;
        tests  = 0;
        for (int i = 0; i < mem_words; i++) mem_model[i] = '0;
        tick(10);
        rst = 1'b0;
        tick(5);
        test_echo();
        test_led();
        test_mem_rw();
        test_step();
        test_run_halt();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
